// ==== compile.f ====
hw/xt_glue_pkg.sv
hw/io_decoder.sv
hw/ems_page_mapper.sv
hw/chipset_data_port.sv
hw/xt_peripheral_glue.sv
dv/xt_glue_asserts.sv
dv/xt_glue_tb.sv

// ==== dv/xt_glue_asserts.sv ====
/*
 * Concurrent checks on the legacy slot chip selects and the EMS bank outputs
 */
`default_nettype none

module xt_glue_asserts (
    input logic                              clock,
    input logic                              reset,
    input logic [xt_glue_pkg::ADDR_W-1:0]    address_i,
    input logic                              io_read_n_i,
    input logic                              io_write_n_i,
    input logic                              address_enable_n_i,
    input logic [xt_glue_pkg::IO_SLOTS-1:0]  chip_select_n_o,
    input logic [xt_glue_pkg::EMS_PAGES-1:0] ems_bank_o
);

    timeunit 1ns;
    timeprecision 100ps;

    import xt_glue_pkg::*;

    int   fail_count = 0;
    logic io_strobe;

    assign io_strobe = ~io_read_n_i | ~io_write_n_i;

    // Slot k selected only for a qualified I/O cycle in its 32-port range
    for (genvar k = 0; k < IO_SLOTS; k++) begin : g_slot
        slot_select: assert property (@(posedge clock) disable iff (reset)
            !chip_select_n_o[k] == (io_strobe && !address_enable_n_i &&
                                    address_i[9:8] == 2'b00 && address_i[7:5] == 3'(k)))
        else begin
            fail_count++;
            $error("Slot %0d chip select disagrees with the bus address", k);
        end
    end

    bank_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(ems_bank_o))
    else begin
        fail_count++;
        $error("More than one EMS bank select is high");
    end

endmodule

`default_nettype wire

// ==== dv/xt_glue_tb.sv ====
/*
 * Testbench for the XT peripheral glue: clock, reset, bus-cycle tasks,
 * directed and random tests, per-test result lines and a watchdog
 */
`default_nettype none

module xt_glue_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import xt_glue_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS  = 5;

    logic                 clock;
    logic                 reset;
    logic [ADDR_W-1:0]    address;
    logic [DATA_W-1:0]    wr_data;
    logic                 io_read_n;
    logic                 io_write_n;
    logic                 address_enable_n;
    logic                 ems_enabled;
    logic [1:0]           ems_frame;
    logic [IO_SLOTS-1:0]  chip_select_n;
    logic [EMS_PAGES-1:0] ems_bank;
    logic [DATA_W-1:0]    rd_data;
    logic                 from_chipset;

    integer seed;
    string  test_name;
    int     test_errors;
    int     tests_failed;
    int     assert_base;

    xt_peripheral_glue i_dut (
        .clock              (clock),
        .reset              (reset),
        .address_i          (address),
        .data_i             (wr_data),
        .io_read_n_i        (io_read_n),
        .io_write_n_i       (io_write_n),
        .address_enable_n_i (address_enable_n),
        .ems_enabled_i      (ems_enabled),
        .ems_frame_i        (ems_frame),
        .chip_select_n_o    (chip_select_n),
        .ems_bank_o         (ems_bank),
        .data_o             (rd_data),
        .from_chipset_o     (from_chipset)
    );

    bind xt_peripheral_glue xt_glue_asserts u_asserts (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // 200 cycles per test
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Watchdog: run did not finish within %0d cycles", NUM_TESTS * 200);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic compare(input string what, input logic [7:0] expected,
                           input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    // One-cycle write strobe, write edge is the second rising edge
    task automatic io_write(input logic [ADDR_W-1:0] addr, input logic [7:0] value);
        @(posedge clock);
        address    <= addr;
        wr_data    <= value;
        io_write_n <= 1'b0;
        @(posedge clock);
        io_write_n <= 1'b1;
    endtask

    task automatic check_read(input string what, input logic [ADDR_W-1:0] addr,
                              input logic [7:0] exp_data, input logic exp_flag);
        @(posedge clock);
        address   <= addr;
        io_read_n <= 1'b0;
        @(posedge clock);
        io_read_n <= 1'b1;
        // Registered output settles after the read edge
        @(negedge clock);
        compare(what, exp_data, rd_data);
        compare({what, " flag"}, {7'b0, exp_flag}, {7'b0, from_chipset});
    endtask

    task automatic check_banks(input string what, input logic [ADDR_W-1:0] addr,
                               input logic [3:0] expected);
        @(posedge clock);
        address <= addr;
        @(negedge clock);
        compare(what, {4'b0, expected}, {4'b0, ems_bank});
    endtask

    task automatic finish_test();
        int failures;
        failures = test_errors + i_dut.u_asserts.fail_count - assert_base;
        if (failures == 0) begin
            $display("PASS %s", test_name);
        end else begin
            $display("FAIL %s with %0d errors", test_name, failures);
            tests_failed++;
        end
        test_errors = 0;
        assert_base = i_dut.u_asserts.fail_count;
    endtask

    initial begin
        logic [7:0] value;
        logic [7:0] other;
        logic [3:0] prefix;

        seed         = 32'hc8595826;
        test_errors  = 0;
        tests_failed = 0;
        assert_base  = 0;
        reset            <= 1'b1;
        address          <= '0;
        wr_data          <= '0;
        io_read_n        <= 1'b1;
        io_write_n       <= 1'b1;
        address_enable_n <= 1'b0;
        ems_enabled      <= 1'b1;
        ems_frame        <= 2'd0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        test_name = "reset_values";
        @(negedge clock);
        compare("flag after reset", 8'h00, {7'b0, from_chipset});
        check_banks("banks after reset", 20'hA0000, 4'b0000);
        check_read("lpt after reset", 20'h00378, 8'hFF, 1'b1);
        finish_test();

        test_name = "slot_decode";
        for (int k = 0; k < 8; k++) begin
            value = 8'($random(seed));
            io_write(20'(k * 32) + 20'(value[4:0]), value);
            check_read("slot read", 20'(k * 32) + 20'(value[4:0]), 8'h00, 1'b0);
        end
        io_write(20'h00100, 8'h11);
        io_write(20'h001E0, 8'h22);
        io_write(20'h002A5, 8'h33);
        io_write(20'h003FF, 8'h44);
        // DMA cycle, AEN high
        @(posedge clock);
        address          <= 20'h00040;
        address_enable_n <= 1'b1;
        io_read_n        <= 1'b0;
        @(posedge clock);
        io_read_n        <= 1'b1;
        address_enable_n <= 1'b0;
        finish_test();

        test_name = "ems_page_map";
        for (int n = 0; n < 4; n++) begin
            value = 8'($random(seed)) & 8'h7F;
            other = 8'h80 + 8'({$random(seed)} % 127);
            io_write(20'h00260 + 20'(n), value);
            check_read("map", 20'h00260 + 20'(n), value, 1'b1);
            io_write(20'h00260 + 20'(n), other);
            check_read("keep", 20'h00260 + 20'(n), value, 1'b1);
            io_write(20'h00260 + 20'(n), 8'hFF);
            check_read("disable", 20'h00260 + 20'(n), 8'hFF, 1'b1);
        end
        @(posedge clock);
        ems_enabled <= 1'b0;
        io_write(20'h00260, 8'h12);
        check_read("ems off read", 20'h00260, 8'h00, 1'b0);
        @(posedge clock);
        ems_enabled <= 1'b1;
        check_read("write while off", 20'h00260, 8'hFF, 1'b1);
        finish_test();

        test_name = "bank_select";
        for (int f = 0; f < 3; f++) begin
            prefix = (f == 0) ? 4'hA : ((f == 1) ? 4'hC : 4'hD);
            @(posedge clock);
            ems_frame <= 2'(f);
            for (int n = 0; n < 4; n++) begin
                io_write(20'h00260 + 20'(n), 8'(n + 1));
            end
            for (int n = 0; n < 4; n++) begin
                check_banks("mapped window", {prefix, 2'(n), 14'h0123}, 4'(1 << n));
            end
            @(posedge clock);
            address   <= {prefix, 2'b01, 14'h0123};
            io_read_n <= 1'b0;
            @(negedge clock);
            compare("io cycle in window", 8'h00, {4'b0, ems_bank});
            @(posedge clock);
            io_read_n <= 1'b1;
        end
        for (int n = 0; n < 4; n++) begin
            io_write(20'h00260 + 20'(n), 8'hFF);
        end
        for (int n = 0; n < 4; n++) begin
            check_banks("disabled page", {4'hD, 2'(n), 14'h0123}, 4'b0000);
        end
        finish_test();

        test_name = "lpt_port";
        value = 8'($random(seed));
        io_write(20'h00378, value);
        check_read("lpt readback", 20'h00378, value, 1'b1);
        check_read("undecoded 3F8h", 20'h003F8, 8'h00, 1'b0);
        check_read("undecoded 2F8h", 20'h002F8, 8'h00, 1'b0);
        finish_test();

        repeat (2) @(posedge clock);
        if (i_dut.u_asserts.fail_count != assert_base) begin
            tests_failed++;
        end
        $display("%0d tests run, %0d failed, %0d assertion failures",
                 NUM_TESTS, tests_failed, i_dut.u_asserts.fail_count);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/chipset_data_port.sv ====
/*
 * LPT data latch and the registered chipset data-bus output
 */
`default_nettype none

module chipset_data_port (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [xt_glue_pkg::DATA_W-1:0] data_i,
    input  logic                           lpt_write_i,
    input  xt_glue_pkg::rd_src_e           rd_src_i,
    input  logic [xt_glue_pkg::DATA_W-1:0] ems_read_data_i,
    output logic [xt_glue_pkg::DATA_W-1:0] data_o,
    output logic                           from_chipset_o
);

    import xt_glue_pkg::*;

    logic [DATA_W-1:0] lpt_data_q;

    // Printer data lines idle high
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lpt_data_q <= 8'hFF;
        end else if (lpt_write_i) begin
            lpt_data_q <= data_i;
        end
    end

    // One cycle from read strobe to bus
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_o         <= '0;
            from_chipset_o <= 1'b0;
        end else begin
            case (rd_src_i)
                RD_EMS: begin
                    data_o         <= ems_read_data_i;
                    from_chipset_o <= 1'b1;
                end
                RD_LPT: begin
                    data_o         <= lpt_data_q;
                    from_chipset_o <= 1'b1;
                end
                default: begin
                    data_o         <= '0;
                    from_chipset_o <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/ems_page_mapper.sv ====
/*
 * EMS page-map registers with a one-stage write pipeline,
 * bank-select decode of the page frame and register readback
 */
`default_nettype none

module ems_page_mapper (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [xt_glue_pkg::ADDR_W-1:0]    address_i,
    input  logic [xt_glue_pkg::DATA_W-1:0]    data_i,
    input  logic                              ems_write_i,
    input  logic                              mem_cycle_i,
    input  logic [1:0]                        ems_frame_i,
    output logic [xt_glue_pkg::EMS_PAGES-1:0] ems_bank_o,
    output logic [xt_glue_pkg::DATA_W-1:0]    ems_read_data_o
);

    import xt_glue_pkg::*;

    ems_cmd_e                       wr_cmd;
    ems_cmd_e                       wr_cmd_q;
    logic                           wr_valid_q;
    logic [$clog2(EMS_PAGES)-1:0]   wr_index_q;
    logic [EMS_MAP_W-1:0]           wr_data_q;

    logic [EMS_MAP_W-1:0]           map_q [EMS_PAGES];
    logic [EMS_PAGES-1:0]           page_en_q;

    logic [3:0]                     frame_prefix;
    logic [$clog2(EMS_PAGES)-1:0]   rd_index;

    // Classify the written byte
    always_comb begin
        if (data_i == EMS_DISABLE_CODE) begin
            wr_cmd = EMS_CMD_DISABLE;
        end else if (data_i < EMS_MAP_LIMIT) begin
            wr_cmd = EMS_CMD_MAP;
        end else begin
            wr_cmd = EMS_CMD_KEEP;
        end
    end

    // First stage holds port index, command and data
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_valid_q <= 1'b0;
            wr_index_q <= '0;
            wr_cmd_q   <= EMS_CMD_KEEP;
        end else begin
            wr_valid_q <= ems_write_i;
            if (ems_write_i) begin
                wr_index_q <= address_i[$clog2(EMS_PAGES)-1:0];
                wr_cmd_q   <= wr_cmd;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ems_write_i) begin
            wr_data_q <= data_i[EMS_MAP_W-1:0];
        end
    end

    // Second stage updates the selected entry
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int n = 0; n < EMS_PAGES; n++) begin
                map_q[n] <= '0;
            end
            page_en_q <= '0;
        end else if (wr_valid_q) begin
            case (wr_cmd_q)
                EMS_CMD_DISABLE: page_en_q[wr_index_q] <= 1'b0;
                EMS_CMD_MAP: begin
                    map_q[wr_index_q]     <= wr_data_q;
                    page_en_q[wr_index_q] <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (ems_frame_i)
            2'd0:    frame_prefix = EMS_FRAME_A;
            2'd1:    frame_prefix = EMS_FRAME_C;
            default: frame_prefix = EMS_FRAME_D;
        endcase
    end

    // 16 KB windows inside the frame, one per page
    always_comb begin
        for (int n = 0; n < EMS_PAGES; n++) begin
            ems_bank_o[n] = mem_cycle_i & page_en_q[n] &
                            (address_i[ADDR_W-1 -: 6] == {frame_prefix, 2'(n)});
        end
    end

    // Disabled pages read back as FFh
    assign rd_index = address_i[$clog2(EMS_PAGES)-1:0];
    assign ems_read_data_o = page_en_q[rd_index] ?
                             {{(DATA_W-EMS_MAP_W){1'b0}}, map_q[rd_index]} :
                             EMS_DISABLE_CODE;

endmodule

`default_nettype wire

// ==== hw/io_decoder.sv ====
/*
 * I/O address decoder: legacy slot chip selects, EMS register window,
 * LPT data port strobes and the read-source select
 */
`default_nettype none

module io_decoder (
    input  logic [xt_glue_pkg::ADDR_W-1:0]   address_i,
    input  logic                             io_read_n_i,
    input  logic                             io_write_n_i,
    input  logic                             address_enable_n_i,
    input  logic                             ems_enabled_i,
    output logic [xt_glue_pkg::IO_SLOTS-1:0] chip_select_n_o,
    output logic                             ems_write_o,
    output logic                             lpt_write_o,
    output xt_glue_pkg::rd_src_e             rd_src_o,
    output logic                             mem_cycle_o
);

    import xt_glue_pkg::*;

    logic io_request;
    logic io_cycle;
    logic io_read;
    logic io_write;
    logic slot_range;
    logic ems_hit;
    logic lpt_hit;

    // Either strobe marks an I/O cycle
    assign io_request = ~io_read_n_i | ~io_write_n_i;
    assign io_cycle   = io_request & ~address_enable_n_i;
    assign io_read    = ~io_read_n_i & ~address_enable_n_i;
    assign io_write   = ~io_write_n_i & ~address_enable_n_i;

    // Anything without an I/O strobe counts as a memory cycle
    assign mem_cycle_o = ~io_request;

    // Slots only live below 100h
    assign slot_range = io_cycle & (address_i[9:8] == 2'b00);

    always_comb begin
        for (int k = 0; k < IO_SLOTS; k++) begin
            chip_select_n_o[k] = ~(slot_range & (address_i[7:5] == 3'(k)));
        end
    end

    // 260h-263h, ignored unless EMS is switched on
    assign ems_hit = ems_enabled_i &
                     (address_i[15:2] == EMS_PORT_BASE[15:2]);

    assign lpt_hit = (address_i[15:0] == LPT_PORT_BASE);

    assign ems_write_o = io_write & ems_hit;
    assign lpt_write_o = io_write & lpt_hit;

    always_comb begin
        if (io_read && ems_hit) begin
            rd_src_o = RD_EMS;
        end else if (io_read && lpt_hit) begin
            rd_src_o = RD_LPT;
        end else begin
            rd_src_o = RD_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== hw/xt_glue_pkg.sv ====
/*
 * Shared widths, I/O port bases and EMS frame prefixes for the XT glue
 * Enums for the EMS write command and the read-source select
 */
`default_nettype none

package xt_glue_pkg;

    // Bus widths
    localparam int ADDR_W    = 20;
    localparam int DATA_W    = 8;

    // EMS page map geometry
    localparam int EMS_PAGES = 4;
    localparam int EMS_MAP_W = 7;

    // Legacy slots in the 000h-0FFh range, 32 ports each
    localparam int IO_SLOTS  = 8;

    localparam logic [15:0] EMS_PORT_BASE = 16'h0260;
    localparam logic [15:0] LPT_PORT_BASE = 16'h0378;

    // Upper nibble of the 64 KB page frame
    localparam logic [3:0] EMS_FRAME_A = 4'hA;
    localparam logic [3:0] EMS_FRAME_C = 4'hC;
    localparam logic [3:0] EMS_FRAME_D = 4'hD;

    localparam logic [DATA_W-1:0] EMS_DISABLE_CODE = 8'hFF;
    localparam logic [DATA_W-1:0] EMS_MAP_LIMIT    = 8'h80;

    typedef enum logic [1:0] {
        EMS_CMD_DISABLE,
        EMS_CMD_MAP,
        EMS_CMD_KEEP
    } ems_cmd_e;

    typedef enum logic [1:0] {
        RD_NONE,
        RD_EMS,
        RD_LPT
    } rd_src_e;

endpackage

`default_nettype wire

// ==== hw/xt_peripheral_glue.sv ====
/*
 * Top level of the XT peripheral glue
 * Connects the I/O decoder, EMS mapper and chipset data port
 */
`default_nettype none

module xt_peripheral_glue (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [xt_glue_pkg::ADDR_W-1:0]    address_i,
    input  logic [xt_glue_pkg::DATA_W-1:0]    data_i,
    input  logic                              io_read_n_i,
    input  logic                              io_write_n_i,
    input  logic                              address_enable_n_i,
    input  logic                              ems_enabled_i,
    input  logic [1:0]                        ems_frame_i,
    output logic [xt_glue_pkg::IO_SLOTS-1:0]  chip_select_n_o,
    output logic [xt_glue_pkg::EMS_PAGES-1:0] ems_bank_o,
    output logic [xt_glue_pkg::DATA_W-1:0]    data_o,
    output logic                              from_chipset_o
);

    import xt_glue_pkg::*;

    logic              ems_write;
    logic              lpt_write;
    logic              mem_cycle;
    rd_src_e           rd_src;
    logic [DATA_W-1:0] ems_read_data;

    io_decoder u_io_decoder (
        .address_i          (address_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .address_enable_n_i (address_enable_n_i),
        .ems_enabled_i      (ems_enabled_i),
        .chip_select_n_o    (chip_select_n_o),
        .ems_write_o        (ems_write),
        .lpt_write_o        (lpt_write),
        .rd_src_o           (rd_src),
        .mem_cycle_o        (mem_cycle)
    );

    ems_page_mapper u_ems_page_mapper (
        .clock              (clock),
        .reset              (reset),
        .address_i          (address_i),
        .data_i             (data_i),
        .ems_write_i        (ems_write),
        .mem_cycle_i        (mem_cycle),
        .ems_frame_i        (ems_frame_i),
        .ems_bank_o         (ems_bank_o),
        .ems_read_data_o    (ems_read_data)
    );

    chipset_data_port u_chipset_data_port (
        .clock              (clock),
        .reset              (reset),
        .data_i             (data_i),
        .lpt_write_i        (lpt_write),
        .rd_src_i           (rd_src),
        .ems_read_data_i    (ems_read_data),
        .data_o             (data_o),
        .from_chipset_o     (from_chipset_o)
    );

endmodule

`default_nettype wire
